// File: verilog/serial_debug_consts.svh
/* Serial debug reporter constants */
`ifndef SERIAL_DEBUG_CONSTS_SVH
`define SERIAL_DEBUG_CONSTS_SVH

// ====================
// Line timing
// ====================

// System clock in Hz
`define DBG_CLK_FREQ 25000000
// UART line rate, 8N1
`define DBG_BAUD 115200

// ====================
// Report layout
// ====================

// Characters per line, CR LF included
`define DBG_MSG_LEN 40
// Pixel coordinate width
`define DBG_COORD_W 10
// Frame and event counter width
`define DBG_FRAME_W 16
// LED status word width
`define DBG_LED_W 8
// Event count saturates here, four decimal digits
`define DBG_COUNT_MAX 9999

`endif

// File: verilog/serial_debug_pkg.sv
/* Serial debug reporter types */
`include "serial_debug_consts.svh"

package serial_debug_pkg;

    // ====================
    // Types
    // ====================

    // One ASCII character on the line
    typedef logic [7:0] ascii_t;

    // Values frozen at one frame tick
    typedef struct packed {
        // Ticks seen before this one
        logic [`DBG_FRAME_W-1:0] frame;
        // Coordinates, already clamped to 999
        logic [`DBG_COORD_W-1:0] x;
        logic [`DBG_COORD_W-1:0] y;
        // Pixel events in the last frame, saturated
        logic [`DBG_FRAME_W-1:0] count;
        // LED status word
        logic [`DBG_LED_W-1:0]   led;
    } snapshot_t;

    // ====================
    // Digit conversion
    // ====================

    // Hex nibble to upper-case ASCII
    function automatic ascii_t hex_char(input logic [3:0] digit);
        ascii_t c;
        if (digit < 4'd10) begin
            // '0' to '9'
            c = 8'h30 + {4'h0, digit};
        end else begin
            // 'A' to 'F', 0x41 minus 10
            c = 8'h37 + {4'h0, digit};
        end
        return c;
    endfunction

    // Decimal digit to ASCII
    // Caller keeps digit within 0 to 9
    function automatic ascii_t dec_char(input logic [3:0] digit);
        ascii_t c;
        c = 8'h30 + {4'h0, digit};
        return c;
    endfunction

endpackage

// File: verilog/uart_tx.sv
/* UART transmitter, 8N1 */
`timescale 1ns/10ps
`include "serial_debug_consts.svh"

module uart_tx
    import serial_debug_pkg::*;
#(
    parameter int CLKS_PER_BIT = `DBG_CLK_FREQ / `DBG_BAUD
) (
    input  logic   clk,
    input  logic   rst_n,
    input  ascii_t char_data,
    input  logic   char_valid,
    output logic   char_ready,
    output logic   tx
);

    // Bit-time counter sizing, at least one bit
    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } tx_state_t;

    tx_state_t        state;
    logic [CNT_W-1:0] bit_cnt;
    logic [2:0]       bit_idx;
    // Remaining data bits, LSB goes out next
    ascii_t           shift_reg;
    logic             bit_done;

    // Byte taken only while idle
    assign char_ready = (state == ST_IDLE);
    assign bit_done   = (bit_cnt == CNT_LAST);

    // ====================
    // Line FSM
    // ====================
    // tx is registered, so each branch sets the level of the next bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
            // Line idles high
            tx      <= 1'b1;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (char_valid) begin
                        // Start bit on the next cycle
                        tx      <= 1'b0;
                        bit_cnt <= '0;
                        state   <= ST_START;
                    end
                end
                ST_START: begin
                    if (bit_done) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        tx      <= shift_reg[0];
                        state   <= ST_DATA;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                ST_DATA: begin
                    if (bit_done) begin
                        bit_cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            // Stop bit
                            tx    <= 1'b1;
                            state <= ST_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= shift_reg[0];
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                ST_STOP: begin
                    // Full stop period before the next byte
                    if (bit_done) begin
                        bit_cnt <= '0;
                        state   <= ST_IDLE;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Shifter, loaded on accept and stepped as each data bit starts
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && char_valid) begin
            shift_reg <= char_data;
        end else if (bit_done && (state == ST_START || state == ST_DATA)) begin
            shift_reg <= {1'b0, shift_reg[7:1]};
        end
    end

endmodule

// File: verilog/frame_snapshot.sv
/* Frame tick snapshot */
`timescale 1ns/10ps
`include "serial_debug_consts.svh"

module frame_snapshot
    import serial_debug_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   frame_tick,
    input  logic [`DBG_COORD_W-1:0] pixel_x,
    input  logic [`DBG_COORD_W-1:0] pixel_y,
    input  logic [`DBG_LED_W-1:0]   led_status,
    input  logic                   pixel_event,
    output snapshot_t              snap,
    output logic                   snap_valid,
    input  logic                   snap_ready
);

    // Three decimal digits on the line
    localparam logic [`DBG_COORD_W-1:0] COORD_MAX = 999;
    localparam logic [`DBG_FRAME_W-1:0] COUNT_MAX = `DBG_COUNT_MAX;

    logic                    tick_d;
    logic                    capture;
    logic [`DBG_FRAME_W-1:0] frame_cnt;
    logic [`DBG_FRAME_W-1:0] event_cnt;

    // First cycle with frame_tick high after low
    assign capture = frame_tick && !tick_d;

    // ====================
    // Counters
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tick_d    <= 1'b0;
            frame_cnt <= '0;
            event_cnt <= '0;
        end else begin
            tick_d <= frame_tick;
            // Captured value first, then the increment
            if (capture) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
            // Events in the capture cycle are dropped
            if (capture) begin
                event_cnt <= '0;
            end else if (pixel_event && event_cnt != COUNT_MAX) begin
                event_cnt <= event_cnt + 1'b1;
            end
        end
    end

    // ====================
    // Snapshot hold
    // ====================
    // A newer capture overwrites a pending one, valid stays up
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            snap_valid <= 1'b0;
        end else if (capture) begin
            snap_valid <= 1'b1;
        end else if (snap_valid && snap_ready) begin
            snap_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            snap.frame <= frame_cnt;
            snap.x     <= (pixel_x > COORD_MAX) ? COORD_MAX : pixel_x;
            snap.y     <= (pixel_y > COORD_MAX) ? COORD_MAX : pixel_y;
            snap.count <= event_cnt;
            snap.led   <= led_status;
        end
    end

endmodule

// File: verilog/report_formatter.sv
/* Report line formatter */
`timescale 1ns/10ps
`include "serial_debug_consts.svh"

module report_formatter
    import serial_debug_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  snapshot_t snap,
    input  logic      snap_valid,
    output logic      snap_ready,
    output ascii_t    char_data,
    output logic      char_valid,
    input  logic      char_ready
);

    localparam int POS_W = $clog2(`DBG_MSG_LEN);
    localparam logic [POS_W-1:0] LAST_POS = POS_W'(`DBG_MSG_LEN - 1);
    // Position of the LED least significant bit
    localparam logic [POS_W-1:0] LED_LAST = 37;

    // Four BCD digits, thousands in the top nibble
    function automatic logic [15:0] to_bcd4(input logic [`DBG_FRAME_W-1:0] value);
        logic [`DBG_FRAME_W-1:0] thou;
        logic [`DBG_FRAME_W-1:0] hund;
        logic [`DBG_FRAME_W-1:0] tens;
        logic [`DBG_FRAME_W-1:0] ones;
        thou = value / 16'd1000;
        hund = (value / 16'd100) % 16'd10;
        tens = (value / 16'd10) % 16'd10;
        ones = value % 16'd10;
        return {thou[3:0], hund[3:0], tens[3:0], ones[3:0]};
    endfunction

    logic                    busy;
    logic [POS_W-1:0]        pos;
    logic                    take_snap;
    logic                    take_char;
    logic [2:0]              led_idx;

    // Split fields of the incoming snapshot
    logic [`DBG_FRAME_W-1:0] x_wide;
    logic [`DBG_FRAME_W-1:0] y_wide;
    logic [15:0]             x_full;
    logic [15:0]             y_full;
    logic [15:0]             v_full;

    // Registered line contents
    logic [`DBG_FRAME_W-1:0] frame_r;
    logic [11:0]             x_bcd;
    logic [11:0]             y_bcd;
    logic [15:0]             v_bcd;
    logic [`DBG_LED_W-1:0]   led_r;

    // One line at a time
    assign snap_ready = !busy;
    assign char_valid = busy;
    assign take_snap  = snap_valid && !busy;
    assign take_char  = busy && char_ready;

    assign x_wide = {{(`DBG_FRAME_W - `DBG_COORD_W){1'b0}}, snap.x};
    assign y_wide = {{(`DBG_FRAME_W - `DBG_COORD_W){1'b0}}, snap.y};
    assign x_full = to_bcd4(x_wide);
    assign y_full = to_bcd4(y_wide);
    assign v_full = to_bcd4(snap.count);

    // LED printed MSB first
    assign led_idx = 3'(LED_LAST - pos);

    // ====================
    // Position sequencer
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            pos  <= '0;
        end else if (take_snap) begin
            busy <= 1'b1;
            pos  <= '0;
        end else if (take_char) begin
            if (pos == LAST_POS) begin
                busy <= 1'b0;
            end else begin
                pos <= pos + 1'b1;
            end
        end
    end

    // Digits split once per line
    always_ff @(posedge clk) begin
        if (take_snap) begin
            frame_r <= snap.frame;
            x_bcd   <= x_full[11:0];
            y_bcd   <= y_full[11:0];
            v_bcd   <= v_full;
            led_r   <= snap.led;
        end
    end

    // ====================
    // Character select
    // ====================
    // "F:hhhh X:ddd Y:ddd V:dddd LED:bbbbbbbb" CR LF
    always_comb begin
        case (pos)
            0:  char_data = "F";
            1, 8, 14, 20, 29: char_data = ":";
            2:  char_data = hex_char(frame_r[15:12]);
            3:  char_data = hex_char(frame_r[11:8]);
            4:  char_data = hex_char(frame_r[7:4]);
            5:  char_data = hex_char(frame_r[3:0]);
            7:  char_data = "X";
            9:  char_data = dec_char(x_bcd[11:8]);
            10: char_data = dec_char(x_bcd[7:4]);
            11: char_data = dec_char(x_bcd[3:0]);
            13: char_data = "Y";
            15: char_data = dec_char(y_bcd[11:8]);
            16: char_data = dec_char(y_bcd[7:4]);
            17: char_data = dec_char(y_bcd[3:0]);
            19: char_data = "V";
            21: char_data = dec_char(v_bcd[15:12]);
            22: char_data = dec_char(v_bcd[11:8]);
            23: char_data = dec_char(v_bcd[7:4]);
            24: char_data = dec_char(v_bcd[3:0]);
            26: char_data = "L";
            27: char_data = "E";
            28: char_data = "D";
            30, 31, 32, 33, 34, 35, 36, 37: char_data = led_r[led_idx] ? "1" : "0";
            // CR
            38: char_data = 8'h0D;
            // LF
            39: char_data = 8'h0A;
            // Field separators at 6, 12, 18 and 25
            default: char_data = " ";
        endcase
    end

endmodule

// File: verilog/serial_debug.sv
/* Serial debug reporter top */
`timescale 1ns/10ps
`include "serial_debug_consts.svh"

module serial_debug
    import serial_debug_pkg::*;
#(
    parameter int CLKS_PER_BIT = `DBG_CLK_FREQ / `DBG_BAUD
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   frame_tick,
    input  logic [`DBG_COORD_W-1:0] pixel_x,
    input  logic [`DBG_COORD_W-1:0] pixel_y,
    input  logic [`DBG_LED_W-1:0]   led_status,
    input  logic                   pixel_event,
    output logic                   tx
);

    // Snapshot to formatter
    snapshot_t snap;
    logic      snap_valid;
    logic      snap_ready;

    // Formatter to transmitter
    ascii_t    char_data;
    logic      char_valid;
    logic      char_ready;

    // ====================
    // Pipeline
    // ====================
    frame_snapshot snapshot0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_tick  (frame_tick),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .led_status  (led_status),
        .pixel_event (pixel_event),
        .snap        (snap),
        .snap_valid  (snap_valid),
        .snap_ready  (snap_ready)
    );

    report_formatter formatter0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .snap       (snap),
        .snap_valid (snap_valid),
        .snap_ready (snap_ready),
        .char_data  (char_data),
        .char_valid (char_valid),
        .char_ready (char_ready)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) uart_tx0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .char_data  (char_data),
        .char_valid (char_valid),
        .char_ready (char_ready),
        .tx         (tx)
    );

endmodule

// File: tests/uart_rx_model.svh
/* UART receiver model */
`ifndef UART_RX_MODEL_SVH
`define UART_RX_MODEL_SVH

// ====================
// Byte receiver
// ====================
// Included inside the testbench module
// Uses its clk, tx and CLKS_PER_BIT
// Samples the line on falling clock edges, away from the tx update
task automatic receive_byte(
    input  int     timeout_cycles,
    output ascii_t data,
    output logic   start_level,
    output logic   stop_level,
    output logic   timed_out
);
    int wait_cnt;
    data        = '0;
    start_level = 1'b1;
    stop_level  = 1'b0;
    timed_out   = 1'b0;
    wait_cnt    = 0;
    // Hunt for the falling edge of the start bit
    @(negedge clk);
    while (tx !== 1'b0 && wait_cnt < timeout_cycles) begin
        @(negedge clk);
        wait_cnt = wait_cnt + 1;
    end
    if (tx !== 1'b0) begin
        timed_out = 1'b1;
    end else begin
        // Middle of the start bit
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        start_level = tx;
        // Data bits, LSB first
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            data[i] = tx;
        end
        // Middle of the stop bit
        repeat (CLKS_PER_BIT) @(negedge clk);
        stop_level = tx;
    end
endtask

`endif

// File: tests/tb_serial_debug.sv
/* Serial debug reporter testbench */
`timescale 1ns/10ps
`include "serial_debug_consts.svh"

module tb_serial_debug
    import serial_debug_pkg::*;
();

    // Short bit time for simulation
    localparam int CLKS_PER_BIT  = 8;
    localparam int NUM_ROWS      = 12;
    // Worst gap up to the next start bit
    localparam int START_TIMEOUT = 4 * CLKS_PER_BIT + 16;
    localparam int IDLE_CYCLES   = 20;

    // One stimulus row
    typedef struct packed {
        logic [`DBG_COORD_W-1:0] x;
        logic [`DBG_COORD_W-1:0] y;
        logic [`DBG_LED_W-1:0]   led;
        // Pixel events before the tick
        logic [15:0]             events;
        // Quiet cycles before the tick
        logic [7:0]              gap;
    } stim_row_t;

    logic                    clk;
    logic                    rst_n;
    logic                    frame_tick;
    logic [`DBG_COORD_W-1:0] pixel_x;
    logic [`DBG_COORD_W-1:0] pixel_y;
    logic [`DBG_LED_W-1:0]   led_status;
    logic                    pixel_event;
    logic                    tx;

    stim_row_t rows [NUM_ROWS];
    ascii_t    exp_line [`DBG_MSG_LEN];
    integer    seed;

    serial_debug #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_tick  (frame_tick),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .led_status  (led_status),
        .pixel_event (pixel_event),
        .tx          (tx)
    );

    // 4 ns period
    always #2 clk = ~clk;

    `include "uart_rx_model.svh"

    // ====================
    // Checks
    // ====================
    task automatic report_failure(input string reason);
        $display("Test failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_char(input ascii_t got, input ascii_t exp, input int pos);
        if (got !== exp) begin
            $display("ERR time=%0t signal=tx char %0d got=8'h%02h exp=8'h%02h",
                     $time, pos, got, exp);
            report_failure("character mismatch");
        end
    endtask

    task automatic check_line(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("ERR time=%0t signal=%s got=%b exp=%b", $time, name, got, exp);
            report_failure("line level mismatch");
        end
    endtask

    // ====================
    // Expected line
    // ====================
    function automatic ascii_t hex_digit(input int value);
        int nib;
        ascii_t c;
        nib = value & 15;
        // '0' is 0x30, 'A' is 0x41
        if (nib < 10) begin
            c = ascii_t'(48 + nib);
        end else begin
            c = ascii_t'(55 + nib);
        end
        return c;
    endfunction

    function automatic ascii_t dec_digit(input int value, input int place);
        return ascii_t'(48 + (value / place) % 10);
    endfunction

    // Labels from the line format with the digit slots filled in below
    task automatic build_line(input int frame, input int x, input int y, input int count,
                              input logic [`DBG_LED_W-1:0] led);
        string tmpl;
        int    xc;
        int    yc;
        int    vc;
        tmpl = "F:.... X:... Y:... V:.... LED:........";
        xc = (x > 999) ? 999 : x;
        yc = (y > 999) ? 999 : y;
        vc = (count > `DBG_COUNT_MAX) ? `DBG_COUNT_MAX : count;
        for (int i = 0; i < 38; i++) begin
            exp_line[i] = tmpl[i];
        end
        for (int i = 0; i < 4; i++) begin
            exp_line[2 + i]  = hex_digit(frame >> (12 - 4 * i));
            exp_line[21 + i] = dec_digit(vc, (i == 0) ? 1000 : (i == 1) ? 100 : (i == 2) ? 10 : 1);
        end
        for (int i = 0; i < 3; i++) begin
            exp_line[9 + i]  = dec_digit(xc, (i == 0) ? 100 : (i == 1) ? 10 : 1);
            exp_line[15 + i] = dec_digit(yc, (i == 0) ? 100 : (i == 1) ? 10 : 1);
        end
        // MSB first
        for (int i = 0; i < `DBG_LED_W; i++) begin
            exp_line[30 + i] = led[`DBG_LED_W - 1 - i] ? "1" : "0";
        end
        exp_line[38] = 8'h0D;
        exp_line[39] = 8'h0A;
    endtask

    // ====================
    // Stimulus
    // ====================
    // x, y, led, events, gap
    task automatic load_table();
        rows[0]  = '{10'd0,    10'd0,    8'hA5, 16'd0,     8'd3};
        rows[1]  = '{10'd639,  10'd479,  8'h81, 16'd17,    8'd5};
        rows[2]  = '{10'd1023, 10'd1023, 8'hFF, 16'd10005, 8'd2};
        rows[3]  = '{10'd5,    10'd998,  8'h00, 16'd1,     8'd0};
        rows[4]  = '{10'd100,  10'd1000, 8'h3C, 16'd250,   8'd7};
        rows[5]  = '{10'd999,  10'd42,   8'h7E, 16'd9999,  8'd1};
        rows[6]  = '{10'd320,  10'd240,  8'h01, 16'd3,     8'd4};
        rows[7]  = '{10'd1000, 10'd7,    8'h80, 16'd64,    8'd2};
        rows[8]  = '{10'd12,   10'd640,  8'h55, 16'd2,     8'd9};
        rows[9]  = '{10'd800,  10'd600,  8'hAA, 16'd128,   8'd1};
        rows[10] = '{10'd1,    10'd1,    8'hC3, 16'd9,     8'd0};
        rows[11] = '{10'd479,  10'd639,  8'h18, 16'd40,    8'd6};
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // No line activity expected
    task automatic idle_cycle();
        next_cycle();
        check_line(tx, 1'b1, "tx");
    endtask

    task automatic apply_events(input int count);
        int left;
        int gap_cycles;
        left = count;
        while (left > 0) begin
            // 0 to 3 quiet cycles between pulses
            gap_cycles = {$random(seed)} % 4;
            repeat (gap_cycles) idle_cycle();
            pixel_event = 1'b1;
            idle_cycle();
            pixel_event = 1'b0;
            left = left - 1;
        end
    endtask

    task automatic send_tick();
        frame_tick = 1'b1;
        idle_cycle();
        frame_tick = 1'b0;
    endtask

    task automatic receive_line(input int line_no);
        ascii_t got;
        logic   start_level;
        logic   stop_level;
        logic   timed_out;
        for (int i = 0; i < `DBG_MSG_LEN; i++) begin
            receive_byte(START_TIMEOUT, got, start_level, stop_level, timed_out);
            if (timed_out) begin
                $display("No start bit on tx within %0d cycles, line %0d char %0d",
                         START_TIMEOUT, line_no, i);
                report_failure("start bit timeout");
            end else begin
                check_line(start_level, 1'b0, "tx start bit");
                check_char(got, exp_line[i], i);
                check_line(stop_level, 1'b1, "tx stop bit");
            end
        end
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        seed        = 39844;
        clk         = 1'b0;
        rst_n       = 1'b0;
        frame_tick  = 1'b0;
        pixel_x     = '0;
        pixel_y     = '0;
        led_status  = '0;
        pixel_event = 1'b0;
        load_table();
        // Two edges in reset
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (IDLE_CYCLES) idle_cycle();
        for (int r = 0; r < NUM_ROWS; r++) begin
            pixel_x    = rows[r].x;
            pixel_y    = rows[r].y;
            led_status = rows[r].led;
            apply_events(int'(rows[r].events));
            repeat (int'(rows[r].gap)) idle_cycle();
            send_tick();
            // F counts the earlier ticks
            build_line(r, int'(rows[r].x), int'(rows[r].y), int'(rows[r].events),
                       rows[r].led);
            receive_line(r);
            // Receiver stops mid stop bit on a falling edge
            idle_cycle();
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: files.f
+incdir+verilog
+incdir+tests
verilog/serial_debug_pkg.sv
verilog/uart_tx.sv
verilog/frame_snapshot.sv
verilog/report_formatter.sv
verilog/serial_debug.sv
tests/tb_serial_debug.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the serial debug testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --top-module tb_serial_debug \
    -f files.f --Mdir obj_dir -o tb_serial_debug > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build did not complete"
    exit 1
fi

./obj_dir/tb_serial_debug > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "Test failed" "$SIM_LOG"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
exit 0
